// File: rvCore_macros.svh
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

//////////////////////////////////////////////////
// Core dimensions
//////////////////////////////////////////////////

// Data path width.
`define XLEN 32

// Architectural register count.
`define NUM_REGS 32

// Register index width.
`define REG_ADDR_W 5

//////////////////////////////////////////////////
// Reset state
//////////////////////////////////////////////////

`define RESET_PC 32'h0000_0000

`endif

// File: rvCorePkg.sv
`default_nettype none

`include "rvCore_macros.svh"

package rvCorePkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`XLEN-1:0]       addr_t;
    typedef logic [31:0]            instr_t;
    typedef logic [`REG_ADDR_W-1:0] regIdx_t;
    typedef logic [6:0]             opcode_t;

    // Base opcodes of the supported subset.
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        OP, OP_IMM, LOAD, STORE, BRANCH, JAL, LUI, AUIPC, ILLEGAL
    } opClass_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
    } aluOp_e;

    typedef enum logic [1:0] {
        ALU_ADD,    // Address, lui and auipc.
        ALU_BRANCH, // Compare only.
        ALU_FUNCT   // Decode funct3 and funct7.
    } aluCtl_e;

    // Operand A source for auipc and lui.
    typedef enum logic [1:0] {
        A_PC   = 2'd0,
        A_ZERO = 2'd1,
        A_RS1  = 2'd2
    } aSel_e;

endpackage

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  rvCorePkg::opcode_t opcode,
    output logic               branch,
    output logic               jump,
    output logic               memRead,
    output logic               memToReg,
    output logic               memWrite,
    output logic               aluSrc,
    output logic               regWrite,
    output rvCorePkg::aSel_e   aSel,
    output rvCorePkg::aluCtl_e aluCtl
);
    import rvCorePkg::*;

    opClass_e opClass;

    always_comb begin
        case (opcode)
            OPC_OP:     opClass = OP;
            OPC_OP_IMM: opClass = OP_IMM;
            OPC_LOAD:   opClass = LOAD;
            OPC_STORE:  opClass = STORE;
            OPC_BRANCH: opClass = BRANCH;
            OPC_JAL:    opClass = JAL;
            OPC_LUI:    opClass = LUI;
            OPC_AUIPC:  opClass = AUIPC;
            default:    opClass = ILLEGAL;
        endcase
    end

    always_comb begin
        branch   = 1'b0;
        jump     = 1'b0;
        memRead  = 1'b0;
        memToReg = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        aSel     = A_RS1;
        aluCtl   = ALU_ADD;
        case (opClass)
            OP: begin
                regWrite = 1'b1;
                aluCtl   = ALU_FUNCT;
            end
            OP_IMM: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluCtl   = ALU_FUNCT;
            end
            LOAD: begin
                memRead  = 1'b1; // Loads only.
                memToReg = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            STORE: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            BRANCH: begin
                branch = 1'b1;
                aluCtl = ALU_BRANCH;
            end
            JAL: begin
                jump     = 1'b1; // Link value comes from pc + 4.
                regWrite = 1'b1;
            end
            LUI: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aSel     = A_ZERO;
            end
            AUIPC: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aSel     = A_PC;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  rvCorePkg::instr_t instr,
    output rvCorePkg::word_t  imm
);
    import rvCorePkg::*;

    opcode_t opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {instr[31:12], 12'b0}; // Upper 20 bits.
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  rvCorePkg::aluCtl_e aluCtl,
    input  logic [2:0]         funct3,
    input  logic               funct7b5,
    input  logic               isImm,
    input  rvCorePkg::word_t   a,
    input  rvCorePkg::word_t   b,
    output rvCorePkg::word_t   result,
    output logic               branchTaken
);
    import rvCorePkg::*;

    aluOp_e op;

    //////////////////////////////////////////////////
    // Operation decode
    //////////////////////////////////////////////////

    always_comb begin
        case (aluCtl)
            ALU_BRANCH: op = SUB;
            ALU_FUNCT: begin
                case (funct3)
                    3'b000:  op = (funct7b5 && !isImm) ? SUB : ADD; // No subi.
                    3'b001:  op = SLL;
                    3'b010:  op = SLT;
                    3'b011:  op = SLTU;
                    3'b100:  op = XOR;
                    3'b101:  op = funct7b5 ? SRA : SRL;
                    3'b110:  op = OR;
                    default: op = AND;
                endcase
            end
            default: op = ADD;
        endcase
    end

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    always_comb begin
        case (op)
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLT:     result = word_t'($signed(a) < $signed(b));
            SLTU:    result = word_t'(a < b);
            SLL:     result = a << b[4:0];
            SRL:     result = a >> b[4:0];
            SRA:     result = $signed(a) >>> b[4:0];
            default: result = a + b;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  branchTaken = (a == b);
            3'b001:  branchTaken = (a != b);
            3'b100:  branchTaken = ($signed(a) < $signed(b));
            3'b101:  branchTaken = ($signed(a) >= $signed(b));
            3'b110:  branchTaken = (a < b);  // Unsigned forms.
            3'b111:  branchTaken = (a >= b);
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_macros.svh"

module regFile (
    input  logic                clk,
    input  logic                rstN,
    input  rvCorePkg::regIdx_t  rs1,
    input  rvCorePkg::regIdx_t  rs2,
    input  rvCorePkg::regIdx_t  rd,
    input  logic                we,
    input  rvCorePkg::word_t    wdata,
    output rvCorePkg::word_t    rdata1,
    output rvCorePkg::word_t    rdata2
);
    import rvCorePkg::*;

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata; // x0 stays untouched.
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: rvCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_macros.svh"

module rvCore (
    input  logic              clk,
    input  logic              rstN,
    output rvCorePkg::addr_t  pc,
    input  rvCorePkg::instr_t instr,
    output rvCorePkg::addr_t  dataAddr,
    output rvCorePkg::word_t  dataWdata,
    output logic              dataWe,
    output logic              dataRe,
    input  rvCorePkg::word_t  dataRdata
);
    import rvCorePkg::*;

    logic    branch;
    logic    jump;
    logic    memRead;
    logic    memToReg;
    logic    memWrite;
    logic    aluSrc;
    logic    regWrite;
    aSel_e   aSel;
    aluCtl_e aluCtl;
    word_t   imm;
    word_t   rdata1;
    word_t   rdata2;
    word_t   opA;
    word_t   opB;
    word_t   aluResult;
    word_t   wbData;
    logic    branchTaken;
    addr_t   pcPlus4;
    addr_t   pcNext;

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        if ((branch && branchTaken) || jump) begin
            pcNext = pc + imm; // B or J immediate.
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    //////////////////////////////////////////////////
    // Decode, operands and writeback
    //////////////////////////////////////////////////

    controlUnit ctrl_i (
        .opcode(instr[6:0]), .branch(branch), .jump(jump), .memRead(memRead),
        .memToReg(memToReg), .memWrite(memWrite), .aluSrc(aluSrc),
        .regWrite(regWrite), .aSel(aSel), .aluCtl(aluCtl)
    );

    immGen imm_i (.instr(instr), .imm(imm));

    regFile rf_i (
        .clk(clk), .rstN(rstN), .rs1(instr[19:15]), .rs2(instr[24:20]),
        .rd(instr[11:7]), .we(regWrite), .wdata(wbData),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    always_comb begin
        case (aSel)
            A_PC:    opA = pc;
            A_ZERO:  opA = '0;
            default: opA = rdata1;
        endcase
    end

    assign opB = aluSrc ? imm : rdata2;

    aluUnit alu_i (
        .aluCtl(aluCtl), .funct3(instr[14:12]), .funct7b5(instr[30]),
        .isImm(aluSrc), .a(opA), .b(opB), .result(aluResult),
        .branchTaken(branchTaken)
    );

    assign dataAddr  = aluResult;
    assign dataWdata = rdata2;
    assign dataWe    = memWrite;
    assign dataRe    = memRead;

    always_comb begin
        if (jump) begin
            wbData = pcPlus4; // Link address.
        end else if (memToReg) begin
            wbData = dataRdata;
        end else begin
            wbData = aluResult;
        end
    end

endmodule

`default_nettype wire

// File: rvCore_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore_sva (
    input logic             clk,
    input logic             rstN,
    input rvCorePkg::addr_t pc,
    input logic             dataWe,
    input logic             dataRe
);
    import rvCorePkg::*;

    noLoadStoreOverlap: assert property (@(posedge clk) disable iff (!rstN)
        !(dataWe && dataRe)) else $error("dataWe and dataRe high together.");

    pcAligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
        else $error("pc is not word aligned.");

    noWriteInReset: assert property (@(posedge clk) !rstN |-> !dataWe)
        else $error("dataWe high while in reset.");

endmodule

bind rvCore rvCore_sva sva_i (
    .clk(clk), .rstN(rstN), .pc(pc), .dataWe(dataWe), .dataRe(dataRe)
);

`default_nettype wire

// File: rvCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_macros.svh"

module rvCore_tb;
    import rvCorePkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_INSTR  = 3000;
    localparam int RST_CYCLES = 5;

    logic   clk;
    logic   rstN;
    addr_t  pc;
    instr_t instr;
    addr_t  dataAddr;
    word_t  dataWdata;
    logic   dataWe;
    logic   dataRe;
    word_t  dataRdata;

    word_t       modelRegs [`NUM_REGS];
    word_t       memModel [64];
    addr_t       expPc;
    logic [31:0] lfsr;
    int          errCount;

    rvCore dut_i (
        .clk(clk), .rstN(rstN), .pc(pc), .instr(instr),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe),
        .dataRe(dataRe), .dataRdata(dataRdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Random source and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr); // One step per bit.
        end
        return val;
    endfunction

    function automatic word_t aluModel(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchModel(input logic [2:0] f3, input word_t a,
                                         input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            errCount++;
            $display("FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // One instruction per cycle
    //////////////////////////////////////////////////

    task automatic stepInstruction();
        logic [2:0]  cls;
        regIdx_t     rd;
        regIdx_t     rs1;
        regIdx_t     rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [5:0]  off;
        word_t       jOff;
        word_t       expAddr;
        word_t       wbVal;
        addr_t       nextPc;
        logic        expWe;
        logic        expRe;
        logic        addrValid;
        logic        writeRd;
        instr_t      ins;
        checkValue("pc", expPc, pc);
        cls       = 3'(takeBits(3));
        rd        = regIdx_t'(takeBits(3)); // x0 to x7.
        rs1       = regIdx_t'(takeBits(3));
        rs2       = regIdx_t'(takeBits(3));
        expWe     = 1'b0;
        expRe     = 1'b0;
        addrValid = 1'b1;
        writeRd   = 1'b1;
        expAddr   = '0;
        wbVal     = '0;
        nextPc    = expPc + 32'd4;
        case (cls)
            3'd0: begin
                f3    = 3'(takeBits(3));
                alt   = ((f3 == 3'b000) || (f3 == 3'b101)) ? 1'(takeBits(1)) : 1'b0;
                ins   = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
                wbVal = aluModel(f3, alt, modelRegs[rs1], modelRegs[rs2]);
            end
            3'd1: begin
                f3    = 3'(takeBits(3));
                imm12 = 12'(takeBits(12));
                if (f3 == 3'b001) imm12[11:5] = 7'b0;
                if (f3 == 3'b101) imm12[11:5] = {1'b0, imm12[10], 5'b0};
                alt   = (f3 == 3'b101) && imm12[10]; // Bit 30 set on addi stays add.
                ins   = {imm12, rs1, f3, rd, 7'b0010011};
                wbVal = aluModel(f3, alt, modelRegs[rs1], {{20{imm12[11]}}, imm12});
            end
            3'd2: begin
                off     = 6'(takeBits(6));
                ins     = {4'b0, off, 2'b0, 5'd0, 3'b010, rd, 7'b0000011};
                expRe   = 1'b1;
                expAddr = {24'b0, off, 2'b0};
                wbVal   = memModel[off];
            end
            3'd3: begin
                off     = 6'(takeBits(6));
                imm12   = {4'b0, off, 2'b0};
                ins     = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], 7'b0100011};
                expWe   = 1'b1;
                writeRd = 1'b0;
                expAddr = {24'b0, off, 2'b0};
            end
            3'd4: begin
                f3        = {1'(takeBits(1)), 1'b0, 1'(takeBits(1))};
                jOff      = (takeBits(4) - 32'd8) << 2; // -32 to 28.
                ins       = {jOff[12], jOff[10:5], rs2, rs1, f3, jOff[4:1], jOff[11],
                             7'b1100011};
                addrValid = 1'b0;
                writeRd   = 1'b0;
                if (branchModel(f3, modelRegs[rs1], modelRegs[rs2])) nextPc = expPc + jOff;
            end
            3'd5: begin
                jOff      = (takeBits(4) - 32'd8) << 2;
                ins       = {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, 7'b1101111};
                addrValid = 1'b0;
                wbVal     = expPc + 32'd4;
                nextPc    = expPc + jOff;
            end
            default: begin
                imm20 = 20'(takeBits(20));
                ins   = {imm20, rd, (cls == 3'd6) ? 7'b0110111 : 7'b0010111};
                wbVal = (cls == 3'd6) ? {imm20, 12'b0} : expPc + {imm20, 12'b0};
            end
        endcase
        if (!expWe && !expRe) expAddr = wbVal; // ALU result on the address port.
        instr     = ins;
        dataRdata = memModel[expAddr[7:2]];
        #1;
        checkValue("dataWe", word_t'(expWe), word_t'(dataWe));
        checkValue("dataRe", word_t'(expRe), word_t'(dataRe));
        if (addrValid) checkValue("dataAddr", expAddr, dataAddr);
        if (expWe) checkValue("dataWdata", modelRegs[rs2], dataWdata);
        if (expWe) memModel[expAddr[7:2]] = modelRegs[rs2];
        if (writeRd && (rd != '0)) modelRegs[rd] = wbVal;
        expPc = nextPc;
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        lfsr      = 32'd45836;
        errCount  = 0;
        expPc     = `RESET_PC;
        rstN      = 1'b0;
        instr     = '0;
        dataRdata = '0;
        for (int i = 0; i < `NUM_REGS; i++) modelRegs[i] = '0;
        for (int i = 0; i < 64; i++) memModel[i] = (word_t'(i) * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
        repeat (RST_CYCLES) begin
            @(negedge clk);
            checkValue("pc", `RESET_PC, pc);
            checkValue("dataWe", '0, word_t'(dataWe));
        end
        rstN = 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            stepInstruction();
            @(negedge clk);
        end
        $display("Errors: %0d", errCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((NUM_INSTR + 20) * CLK_PERIOD);
        $display("Timeout: run did not complete %0d instructions in time.", NUM_INSTR);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
rvCorePkg.sv
controlUnit.sv
immGen.sv
aluUnit.sv
regFile.sv
rvCore.sv
rvCore_sva.sv
rvCore_tb.sv
